// File: hw/cache_pkg.sv
// Tag width is fixed for 16 sets (SET_W of 4) and no line data is modeled, only tag, MESI and age
package cache_pkg;

    // Address split
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 6;
    // Index width for the default of 16 sets
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;

    // Age width, enough for up to 8 ways
    localparam int LRU_W = 3;
    // Way number as reported in a result
    localparam int WAY_W = 3;
    // Statistics counter width
    localparam int CNT_W = 16;

    // Trace operation codes, print (9) is not a member and is dropped
    typedef enum logic [3:0] {
        OP_READ  = 4'd0,
        OP_WRITE = 4'd1,
        OP_FETCH = 4'd2,
        OP_INVAL = 4'd3,
        OP_SNOOP = 4'd4,
        OP_CLEAR = 4'd8
    } op_e;

    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    // One strobed trace command
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
    } cache_cmd_t;

    // Command after address split and cache steering
    typedef struct packed {
        op_e                op;
        logic               is_instr;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } decoded_cmd_t;

    // One way of a set, age 0 is the most recent
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        mesi_e            mesi;
        logic [LRU_W-1:0] age;
    } cache_line_t;

    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] way;
        // State of the selected line after the update
        mesi_e            mesi;
        // Victim was Modified and gets replaced
        logic             writeback;
        logic             is_instr;
    } cache_result_t;

    typedef struct packed {
        logic [CNT_W-1:0] reads;
        logic [CNT_W-1:0] writes;
        logic [CNT_W-1:0] fetches;
        logic [CNT_W-1:0] hits;
        logic [CNT_W-1:0] misses;
    } cache_stats_t;

endpackage

// File: hw/trace_decoder.sv
// One command per cycle on a bare strobe, op 9 and unknown codes are dropped without a result
`timescale 1ns/1ns

module trace_decoder #(
    parameter int SET_W = 4
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     cmd_valid_i,
    input  cache_pkg::cache_cmd_t    cmd_i,
    output logic                     dec_valid_o,
    output cache_pkg::decoded_cmd_t  dec_o,
    output logic                     clear_o
);

    // Ops that look up a set
    logic is_lookup;
    // Op that wipes both caches
    logic is_clear;

    assign is_lookup = cmd_i.op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE,
                                        cache_pkg::OP_FETCH, cache_pkg::OP_INVAL,
                                        cache_pkg::OP_SNOOP};
    assign is_clear  = (cmd_i.op == cache_pkg::OP_CLEAR);

    // Strobes, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            clear_o     <= 1'b0;
        end else begin
            dec_valid_o <= cmd_valid_i && is_lookup;
            // Clear lasts one cycle
            clear_o     <= cmd_valid_i && is_clear;
        end
    end

    // Payload, only meaningful while dec_valid_o is high
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            dec_o.op       <= cmd_i.op;
            // Only fetches go to the instruction cache
            dec_o.is_instr <= (cmd_i.op == cache_pkg::OP_FETCH);
            // Tag sits above index and byte offset
            dec_o.tag      <= cmd_i.addr[cache_pkg::OFFSET_W + SET_W +: cache_pkg::TAG_W];
            dec_o.index    <= cmd_i.addr[cache_pkg::OFFSET_W +: SET_W];
        end
    end

endmodule

// File: hw/tag_store.sv
// Whole set read combinationally and written back in one edge, clear wins over a write
`timescale 1ns/1ns

module tag_store #(
    parameter int WAYS  = 8,
    parameter int SET_W = 4
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   clear_i,
    input  logic [SET_W-1:0]       index_i,
    output cache_pkg::cache_line_t set_o [WAYS],
    input  logic                   wr_en_i,
    input  cache_pkg::cache_line_t set_i [WAYS]
);

    localparam int SETS = 2 ** SET_W;

    // Tag, state and age of every way of every set
    cache_pkg::cache_line_t mem [SETS][WAYS];

    // Lookup path, no register between index and set
    assign set_o = mem[index_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            // All lines invalid
            // Way w starts with age w so ages stay a permutation
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    mem[s][w].tag  <= '0;
                    mem[s][w].mesi <= cache_pkg::MESI_I;
                    mem[s][w].age  <= w[cache_pkg::LRU_W-1:0];
                end
            end
        end else if (wr_en_i) begin
            // Rewritten set goes back at the index it came from
            mem[index_i] <= set_i;
        end
    end

endmodule

// File: hw/set_processor.sv
// Purely combinational, WAYS from 2 to 8, ages are expected to be a permutation of 0..WAYS-1
`timescale 1ns/1ns

module set_processor #(
    parameter int WAYS = 8
) (
    input  logic                     dec_valid_i,
    input  cache_pkg::decoded_cmd_t  dec_i,
    input  cache_pkg::cache_line_t   set_i [WAYS],
    output cache_pkg::cache_line_t   set_o [WAYS],
    output logic                     wr_en_o,
    output cache_pkg::cache_line_t   sel_line_o,
    input  cache_pkg::mesi_e         next_mesi_i,
    output cache_pkg::cache_result_t result_o
);

    // Read, write or fetch, the ops that touch ages and tags
    logic                            is_access;
    logic                            hit;
    logic [cache_pkg::WAY_W-1:0]     hit_way;
    // Oldest way overall
    logic [cache_pkg::WAY_W-1:0]     old_way;
    logic [cache_pkg::LRU_W-1:0]     old_age;
    // Oldest invalid way, if any
    logic                            inv_found;
    logic [cache_pkg::WAY_W-1:0]     inv_way;
    logic [cache_pkg::LRU_W-1:0]     inv_age;
    logic [cache_pkg::WAY_W-1:0]     victim;
    logic [cache_pkg::WAY_W-1:0]     sel_way;

    assign is_access = dec_i.op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE,
                                        cache_pkg::OP_FETCH};

    // Hit search and victim choice
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        old_way   = '0;
        old_age   = '0;
        inv_found = 1'b0;
        inv_way   = '0;
        inv_age   = '0;
        for (int w = 0; w < WAYS; w++) begin
            // Only a valid way can hit
            if (set_i[w].mesi != cache_pkg::MESI_I && set_i[w].tag == dec_i.tag) begin
                hit     = 1'b1;
                hit_way = w[cache_pkg::WAY_W-1:0];
            end
            if (set_i[w].age > old_age) begin
                old_age = set_i[w].age;
                old_way = w[cache_pkg::WAY_W-1:0];
            end
            if (set_i[w].mesi == cache_pkg::MESI_I && (!inv_found || set_i[w].age > inv_age)) begin
                inv_found = 1'b1;
                inv_age   = set_i[w].age;
                inv_way   = w[cache_pkg::WAY_W-1:0];
            end
        end
        // Invalid ways are preferred over the oldest valid one
        victim = inv_found ? inv_way : old_way;
        // Invalidate and snoop misses point at way 0
        if (hit) begin
            sel_way = hit_way;
        end else if (is_access) begin
            sel_way = victim;
        end else begin
            sel_way = '0;
        end
        // Current line of the selected way, for the MESI logic
        sel_line_o = set_i[0];
        for (int w = 0; w < WAYS; w++) begin
            if (w[cache_pkg::WAY_W-1:0] == sel_way) begin
                sel_line_o = set_i[w];
            end
        end
    end

    // Set rewrite
    always_comb begin
        set_o = set_i;
        for (int w = 0; w < WAYS; w++) begin
            if (w[cache_pkg::WAY_W-1:0] == sel_way) begin
                // Snoop or invalidate only change a line that hit
                if (is_access || hit) begin
                    set_o[w].mesi = next_mesi_i;
                end
                if (is_access) begin
                    set_o[w].tag = dec_i.tag;
                    set_o[w].age = '0;
                end
            end else if (is_access && set_i[w].age < sel_line_o.age) begin
                // Younger than the selected way, ages by one
                set_o[w].age = set_i[w].age + 1'b1;
            end
        end
    end

    // Top already steers the strobe to one cache
    assign wr_en_o = dec_valid_i;

    always_comb begin
        result_o.hit       = hit;
        result_o.way       = sel_way;
        result_o.mesi      = next_mesi_i;
        // Dirty victim leaves the cache
        result_o.writeback = is_access && !hit && (sel_line_o.mesi == cache_pkg::MESI_M);
        result_o.is_instr  = dec_i.is_instr;
    end

endmodule

// File: hw/mesi_fsm.sv
// Next state only, no bus transactions or other processors are modeled
`timescale 1ns/1ns

module mesi_fsm (
    input  cache_pkg::op_e   op_i,
    input  logic             hit_i,
    input  cache_pkg::mesi_e mesi_i,
    output cache_pkg::mesi_e mesi_o
);

    always_comb begin
        // Default keeps the line as it is
        mesi_o = mesi_i;
        case (op_i)
            cache_pkg::OP_READ, cache_pkg::OP_FETCH: begin
                // Single processor, so a fill is always exclusive
                if (!hit_i) begin
                    mesi_o = cache_pkg::MESI_E;
                end
            end
            cache_pkg::OP_WRITE: begin
                mesi_o = cache_pkg::MESI_M;
            end
            cache_pkg::OP_INVAL: begin
                if (hit_i) begin
                    mesi_o = cache_pkg::MESI_I;
                end
            end
            cache_pkg::OP_SNOOP: begin
                // M, E or S all drop to shared
                if (hit_i) begin
                    mesi_o = cache_pkg::MESI_S;
                end
            end
            default: begin
                mesi_o = mesi_i;
            end
        endcase
    end

endmodule

// File: hw/cache_stats.sv
// Counters wrap at 16 bits and are cleared only by reset, op 8 leaves them alone
`timescale 1ns/1ns

module cache_stats (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     dec_valid_i,
    input  cache_pkg::op_e           op_i,
    input  cache_pkg::cache_result_t result_i,
    output logic                     result_valid_o,
    output cache_pkg::cache_result_t result_o,
    output cache_pkg::cache_stats_t  stats_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            stats_o        <= '0;
        end else begin
            // One result per looked-up command, never held
            result_valid_o <= dec_valid_i;
            if (dec_valid_i) begin
                case (op_i)
                    cache_pkg::OP_READ:  stats_o.reads   <= stats_o.reads + 1'b1;
                    cache_pkg::OP_WRITE: stats_o.writes  <= stats_o.writes + 1'b1;
                    cache_pkg::OP_FETCH: stats_o.fetches <= stats_o.fetches + 1'b1;
                    default: ;
                endcase
                // Snoop and invalidate do not count as hits or misses
                if (op_i inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE, cache_pkg::OP_FETCH}) begin
                    if (result_i.hit) begin
                        stats_o.hits <= stats_o.hits + 1'b1;
                    end else begin
                        stats_o.misses <= stats_o.misses + 1'b1;
                    end
                end
            end
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            result_o <= result_i;
        end
    end

endmodule

// File: hw/split_cache_top.sv
// Result two edges after the command strobe, SET_W must match the tag width in cache_pkg
`timescale 1ns/1ns

module split_cache_top #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4,
    parameter int SET_W  = 4
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     cmd_valid_i,
    input  cache_pkg::cache_cmd_t    cmd_i,
    output logic                     result_valid_o,
    output cache_pkg::cache_result_t result_o,
    output cache_pkg::cache_stats_t  stats_o
);

    logic                     dec_valid;
    cache_pkg::decoded_cmd_t  dec;
    logic                     clear;
    // Strobe steered to the target cache
    logic                     d_valid;
    logic                     i_valid;
    cache_pkg::cache_line_t   d_set_rd [D_WAYS];
    cache_pkg::cache_line_t   d_set_wr [D_WAYS];
    cache_pkg::cache_line_t   i_set_rd [I_WAYS];
    cache_pkg::cache_line_t   i_set_wr [I_WAYS];
    logic                     d_wr_en;
    logic                     i_wr_en;
    cache_pkg::cache_line_t   d_sel_line;
    cache_pkg::cache_line_t   i_sel_line;
    cache_pkg::cache_result_t d_res;
    cache_pkg::cache_result_t i_res;
    // Shared MESI path
    cache_pkg::cache_line_t   sel_line;
    logic                     sel_hit;
    cache_pkg::mesi_e         next_mesi;
    cache_pkg::cache_result_t res_sel;

    trace_decoder #(.SET_W(SET_W)) u_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .dec_valid_o (dec_valid),
        .dec_o       (dec),
        .clear_o     (clear)
    );

    assign d_valid = dec_valid && !dec.is_instr;
    assign i_valid = dec_valid && dec.is_instr;

    tag_store #(.WAYS(D_WAYS), .SET_W(SET_W)) u_d_store (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear),
        .index_i (dec.index),
        .set_o   (d_set_rd),
        .wr_en_i (d_wr_en),
        .set_i   (d_set_wr)
    );

    tag_store #(.WAYS(I_WAYS), .SET_W(SET_W)) u_i_store (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (clear),
        .index_i (dec.index),
        .set_o   (i_set_rd),
        .wr_en_i (i_wr_en),
        .set_i   (i_set_wr)
    );

    set_processor #(.WAYS(D_WAYS)) u_d_proc (
        .dec_valid_i (d_valid),
        .dec_i       (dec),
        .set_i       (d_set_rd),
        .set_o       (d_set_wr),
        .wr_en_o     (d_wr_en),
        .sel_line_o  (d_sel_line),
        .next_mesi_i (next_mesi),
        .result_o    (d_res)
    );

    set_processor #(.WAYS(I_WAYS)) u_i_proc (
        .dec_valid_i (i_valid),
        .dec_i       (dec),
        .set_i       (i_set_rd),
        .set_o       (i_set_wr),
        .wr_en_o     (i_wr_en),
        .sel_line_o  (i_sel_line),
        .next_mesi_i (next_mesi),
        .result_o    (i_res)
    );

    // Selected line of the active cache
    assign sel_line = dec.is_instr ? i_sel_line : d_sel_line;
    // The selected line is a hit exactly when it is valid and holds the decoded tag
    // Taken from the line, so the MESI path does not loop back through the result
    assign sel_hit  = (sel_line.mesi != cache_pkg::MESI_I) && (sel_line.tag == dec.tag);

    mesi_fsm u_mesi (
        .op_i   (dec.op),
        .hit_i  (sel_hit),
        .mesi_i (sel_line.mesi),
        .mesi_o (next_mesi)
    );

    assign res_sel = dec.is_instr ? i_res : d_res;

    cache_stats u_stats (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dec_valid_i    (dec_valid),
        .op_i           (dec.op),
        .result_i       (res_sel),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .stats_o        (stats_o)
    );

endmodule

// File: tb/split_cache_properties.sv
// Checks result timing and reported state only, tags and ages are left to the testbench model
`timescale 1ns/1ns

module split_cache_properties (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     cmd_valid_i,
    input cache_pkg::cache_cmd_t    cmd_i,
    input logic                     result_valid_i,
    input cache_pkg::cache_result_t result_i
);

    // Strobed command that looks up a set
    logic lookup;

    assign lookup = cmd_valid_i && (cmd_i.op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE,
                                                     cache_pkg::OP_FETCH, cache_pkg::OP_INVAL,
                                                     cache_pkg::OP_SNOOP});

    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !result_valid_i)
        else $error("result_valid_o high while reset is held");

    // Two edges from sampling to result
    a_result_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        lookup |-> ##2 result_valid_i)
        else $error("no result two edges after a lookup command");

    // No result without a lookup two edges back, so clear and print stay silent
    a_no_stray_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        result_valid_i |-> $past(lookup, 2))
        else $error("result without a matching lookup command");

    a_access_valid_state: assert property (@(posedge clk) disable iff (!rst_n_i)
        result_valid_i && ($past(cmd_i.op, 2) inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE,
                                                       cache_pkg::OP_FETCH})
        |-> result_i.mesi != cache_pkg::MESI_I)
        else $error("read, write or fetch reported state I");

endmodule

bind split_cache_top split_cache_properties u_props (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (cmd_i),
    .result_valid_i (result_valid_o),
    .result_i       (result_o)
);

// File: tb/split_cache_tb.sv
// Directed tests then 200 back-to-back random commands, expected values come from a model of both caches
`timescale 1ns/1ns

module split_cache_tb;

    localparam int D_WAYS    = 8;
    localparam int I_WAYS    = 4;
    localparam int SET_W     = 4;
    localparam int SETS      = 2 ** SET_W;
    // Commands sent by the five directed tests
    localparam int DIR_CMDS  = 60;
    localparam int RAND_CMDS = 200;
    localparam int LIMIT     = 2 * (DIR_CMDS + RAND_CMDS) + 50;

    logic                     clk;
    logic                     rst_n_i;
    logic                     cmd_valid_i;
    cache_pkg::cache_cmd_t    cmd_i;
    logic                     result_valid_o;
    cache_pkg::cache_result_t result_o;
    cache_pkg::cache_stats_t  stats_o;

    // Model state, cache 0 is data and cache 1 is instruction
    cache_pkg::cache_line_t   m_line [2][SETS][D_WAYS];
    cache_pkg::cache_stats_t  exp_stats;
    // Expected results in command order, with the test that issued each one
    cache_pkg::cache_result_t exp_q [$];
    string                    name_q [$];
    string                    test_name;
    int                       err_result = 0;
    int                       err_stats  = 0;
    int                       err_other  = 0;
    int                       cycles     = 0;
    integer                   seed       = 32'h4ace572d;

    split_cache_top #(.D_WAYS(D_WAYS), .I_WAYS(I_WAYS), .SET_W(SET_W)) dut0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_i          (cmd_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .stats_o        (stats_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Every line invalid, way w at age w
    function automatic void model_reset();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < D_WAYS; w++) begin
                    m_line[c][s][w].tag  = '0;
                    m_line[c][s][w].mesi = cache_pkg::MESI_I;
                    m_line[c][s][w].age  = w[cache_pkg::LRU_W-1:0];
                end
            end
        end
    endfunction

    // Applies one command to the model and returns the result it must produce
    function automatic cache_pkg::cache_result_t ref_access(input cache_pkg::cache_cmd_t cmd);
        cache_pkg::cache_result_t    res;
        cache_pkg::mesi_e            cur;
        cache_pkg::mesi_e            nxt;
        logic [cache_pkg::TAG_W-1:0] tag;
        logic                        hit;
        logic                        acc;
        int                          c;
        int                          ways;
        int                          idx;
        int                          sel;
        res = '0;
        if (cmd.op == cache_pkg::OP_CLEAR) begin
            model_reset();
            return res;
        end
        // Print and unknown codes leave no trace
        if (!(cmd.op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE, cache_pkg::OP_FETCH,
                             cache_pkg::OP_INVAL, cache_pkg::OP_SNOOP})) begin
            return res;
        end
        c    = (cmd.op == cache_pkg::OP_FETCH) ? 1 : 0;
        ways = (c == 1) ? I_WAYS : D_WAYS;
        tag  = cmd.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
        idx  = int'(cmd.addr[cache_pkg::OFFSET_W +: SET_W]);
        acc  = cmd.op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE, cache_pkg::OP_FETCH};
        hit  = 1'b0;
        sel  = 0;
        for (int w = 0; w < ways; w++) begin
            if (m_line[c][idx][w].mesi != cache_pkg::MESI_I && m_line[c][idx][w].tag == tag) begin
                hit = 1'b1;
                sel = w;
            end
        end
        if (!hit && acc) begin
            // Oldest invalid way first
            sel = -1;
            for (int w = 0; w < ways; w++) begin
                if (m_line[c][idx][w].mesi == cache_pkg::MESI_I &&
                    (sel < 0 || m_line[c][idx][w].age > m_line[c][idx][sel].age)) begin
                    sel = w;
                end
            end
            // Then the oldest of all
            if (sel < 0) begin
                sel = 0;
                for (int w = 0; w < ways; w++) begin
                    if (m_line[c][idx][w].age > m_line[c][idx][sel].age) begin
                        sel = w;
                    end
                end
            end
            res.writeback = (m_line[c][idx][sel].mesi == cache_pkg::MESI_M);
        end
        cur = m_line[c][idx][sel].mesi;
        case (cmd.op)
            cache_pkg::OP_READ, cache_pkg::OP_FETCH: nxt = hit ? cur : cache_pkg::MESI_E;
            cache_pkg::OP_WRITE:                     nxt = cache_pkg::MESI_M;
            cache_pkg::OP_INVAL:                     nxt = hit ? cache_pkg::MESI_I : cur;
            default:                                 nxt = hit ? cache_pkg::MESI_S : cur;
        endcase
        if (acc) begin
            // Younger ways age by one, the selected way becomes newest
            for (int w = 0; w < ways; w++) begin
                if (w != sel && m_line[c][idx][w].age < m_line[c][idx][sel].age) begin
                    m_line[c][idx][w].age = m_line[c][idx][w].age + 3'd1;
                end
            end
            m_line[c][idx][sel].tag  = tag;
            m_line[c][idx][sel].age  = '0;
            m_line[c][idx][sel].mesi = nxt;
            if (cmd.op == cache_pkg::OP_READ) begin
                exp_stats.reads = exp_stats.reads + 16'd1;
            end else if (cmd.op == cache_pkg::OP_WRITE) begin
                exp_stats.writes = exp_stats.writes + 16'd1;
            end else begin
                exp_stats.fetches = exp_stats.fetches + 16'd1;
            end
            if (hit) begin
                exp_stats.hits = exp_stats.hits + 16'd1;
            end else begin
                exp_stats.misses = exp_stats.misses + 16'd1;
            end
        end else if (hit) begin
            m_line[c][idx][sel].mesi = nxt;
        end
        res.hit      = hit;
        res.way      = sel[cache_pkg::WAY_W-1:0];
        res.mesi     = nxt;
        res.is_instr = (c == 1);
        return res;
    endfunction

    // Fields of a result as text
    function automatic string result_text(input cache_pkg::cache_result_t r);
        return $sformatf("hit=%0b way=%0d mesi=%s wb=%0b instr=%0b",
                         r.hit, r.way, r.mesi.name(), r.writeback, r.is_instr);
    endfunction

    // Counters as text
    function automatic string stats_text(input cache_pkg::cache_stats_t s);
        return $sformatf("r=%0d w=%0d f=%0d hit=%0d miss=%0d",
                         s.reads, s.writes, s.fetches, s.hits, s.misses);
    endfunction

    task automatic check_result(input string name, input cache_pkg::cache_result_t exp,
                                input cache_pkg::cache_result_t act);
        if (act !== exp) begin
            err_result++;
            $display("ERROR %s: expected %s actual %s", name, result_text(exp),
                     result_text(act));
        end
    endtask

    task automatic check_stats(input string name, input cache_pkg::cache_stats_t exp,
                               input cache_pkg::cache_stats_t act);
        if (act !== exp) begin
            err_stats++;
            $display("ERROR %s: expected %s actual %s", name, stats_text(exp),
                     stats_text(act));
        end
    endtask

    // Drives one command for one cycle, entered 1 ns after a rising edge
    task automatic send_cmd(input cache_pkg::op_e op, input logic [21:0] tag,
                            input logic [3:0] idx, input logic [5:0] off);
        cache_pkg::cache_cmd_t    cmd;
        cache_pkg::cache_result_t exp;
        cmd.op   = op;
        cmd.addr = {tag, idx, off};
        exp      = ref_access(cmd);
        if (op inside {cache_pkg::OP_READ, cache_pkg::OP_WRITE, cache_pkg::OP_FETCH,
                       cache_pkg::OP_INVAL, cache_pkg::OP_SNOOP}) begin
            exp_q.push_back(exp);
            name_q.push_back(test_name);
        end
        cmd_i       = cmd;
        cmd_valid_i = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid_i = 1'b0;
    endtask

    // Results are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n_i && result_valid_o) begin
            if (exp_q.size() == 0) begin
                err_other++;
                $display("A result arrived with no command outstanding");
            end else begin
                check_result(name_q.pop_front(), exp_q.pop_front(), result_o);
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          opn;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        exp_stats   = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // Nine tags into data set 3, then four hits
        test_name = "fill_hit";
        for (int t = 0; t < 9; t++) begin
            send_cmd(cache_pkg::OP_READ, 22'h100 + 22'(t), 4'd3, 6'(t));
        end
        for (int t = 1; t < 5; t++) begin
            send_cmd(cache_pkg::OP_READ, 22'h100 + 22'(t), 4'd3, 6'd0);
        end

        // Line 0x200 goes M and is evicted last with a write-back
        test_name = "lru_writeback";
        for (int t = 0; t < 8; t++) begin
            send_cmd(cache_pkg::OP_READ, 22'h200 + 22'(t), 4'd5, 6'd8);
        end
        send_cmd(cache_pkg::OP_WRITE, 22'h200, 4'd5, 6'd8);
        for (int t = 0; t < 8; t++) begin
            send_cmd((t == 3) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ,
                     22'h210 + 22'(t), 4'd5, 6'd0);
        end

        // Invalidated way is refilled before the oldest one
        test_name = "invalid_way";
        for (int t = 0; t < 8; t++) begin
            send_cmd(cache_pkg::OP_READ, 22'h300 + 22'(t), 4'd7, 6'd0);
        end
        send_cmd(cache_pkg::OP_INVAL, 22'h303, 4'd7, 6'd0);
        send_cmd(cache_pkg::OP_INVAL, 22'h3ff, 4'd7, 6'd0);
        send_cmd(cache_pkg::OP_READ, 22'h308, 4'd7, 6'd0);

        test_name = "snoop";
        send_cmd(cache_pkg::OP_READ, 22'h400, 4'd9, 6'd0);
        send_cmd(cache_pkg::OP_WRITE, 22'h401, 4'd9, 6'd0);
        send_cmd(cache_pkg::OP_SNOOP, 22'h400, 4'd9, 6'd0);
        send_cmd(cache_pkg::OP_SNOOP, 22'h401, 4'd9, 6'd0);
        send_cmd(cache_pkg::OP_SNOOP, 22'h4ff, 4'd9, 6'd0);
        send_cmd(cache_pkg::OP_READ, 22'h400, 4'd9, 6'd0);

        // Same tags as the data set, then clear and a print that is dropped
        test_name = "icache_clear";
        for (int t = 0; t < 5; t++) begin
            send_cmd(cache_pkg::OP_FETCH, 22'h100 + 22'(t), 4'd3, 6'd0);
        end
        for (int t = 5; t < 9; t++) begin
            send_cmd(cache_pkg::OP_READ, 22'h100 + 22'(t), 4'd3, 6'd0);
        end
        send_cmd(cache_pkg::OP_CLEAR, 22'h0, 4'd0, 6'd0);
        send_cmd(cache_pkg::op_e'(4'd9), 22'h0, 4'd0, 6'd0);
        send_cmd(cache_pkg::OP_READ, 22'h105, 4'd3, 6'd0);
        send_cmd(cache_pkg::OP_FETCH, 22'h104, 4'd3, 6'd0);

        // Twelve tags over sets 1 to 3 so both caches evict
        test_name = "random_mix";
        for (int n = 0; n < RAND_CMDS; n++) begin
            r   = $random(seed);
            opn = int'(r[7:0]) % 5;
            send_cmd(cache_pkg::op_e'(opn[3:0]), 22'h500 + 22'(int'(r[11:8]) % 12),
                     4'(1 + int'(r[13:12]) % 3), r[19:14]);
        end

        // Last results trail the last command by two edges
        for (int n = 0; n < 8 && exp_q.size() != 0; n++) begin
            @(posedge clk);
        end
        #1;
        if (exp_q.size() != 0) begin
            err_other++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        check_stats("final_stats", exp_stats, stats_o);
        $display("Errors: result %0d, stats %0d, other %0d", err_result, err_stats, err_other);
        if (err_result + err_stats + err_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
hw/cache_pkg.sv
hw/trace_decoder.sv
hw/tag_store.sv
hw/set_processor.sv
hw/mesi_fsm.sv
hw/cache_stats.sv
hw/split_cache_top.sv
tb/split_cache_properties.sv
tb/split_cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -f files.f --top-module split_cache_tb \
    -o split_cache_sim || { echo "Build failed"; exit 1; }
./obj_dir/split_cache_sim > "$LOG" 2>&1 ; cat "$LOG"
grep -q "Simulation failed" "$LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" || { echo "Result: FAIL (run ended early)"; exit 1; }
echo "Result: PASS"
